// File: include/axibram_defs.svh
// sizes shared by the write-side BRAM slave and its testbench
// memory is word addressed, every beat is assumed to be one full 32-bit word
// burst length field is AXI3 width, so bursts are 1..16 beats
// FIFO depth should be a power of two, ready drops at half of it
`ifndef AXIBRAM_DEFS_SVH
`define AXIBRAM_DEFS_SVH

// word-address bits of the memory, 1024 words
`define AXIBRAM_ADDR_BITS 10

// awid / wid / bid width of the GP port
`define AXIBRAM_ID_BITS 12

// data bus width
`define AXIBRAM_DATA_BITS 32

// one strobe per byte lane
`define AXIBRAM_STRB_BITS (`AXIBRAM_DATA_BITS / 8)

// awlen width, AXI3
`define AXIBRAM_LEN_BITS 4

// entries per queue (address, data, response)
`define AXIBRAM_FIFO_DEPTH 4

`endif

// File: logic/axibram_pkg.sv
// types for the write-side BRAM slave
// response codes other than OKAY are listed for completeness but never produced
`default_nettype none

`include "axibram_defs.svh"

package axibram_pkg;

   // AXI burst type, awburst encoding
   typedef enum logic [1:0] {
      BURST_FIXED    = 2'b00, // same word every beat
      BURST_INCR     = 2'b01, // word + 1
      BURST_WRAP     = 2'b10, // +1 inside aligned window
      BURST_RESERVED = 2'b11  // treated as fixed
   } axi_burst_e;

   // write response code
   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_EXOKAY = 2'b01, // unused, no exclusive access
      RESP_SLVERR = 2'b10, // unused
      RESP_DECERR = 2'b11  // unused
   } axi_resp_e;

   // one memory word, seen whole or by byte lane
   typedef union packed {
      logic [`AXIBRAM_DATA_BITS-1:0]       word;  // read view
      logic [`AXIBRAM_STRB_BITS-1:0][7:0]  bytes; // strobed write view
   } bram_word_u;

endpackage

`default_nettype wire

// File: logic/sync_fifo.sv
// single-clock FIFO, head word shown on dout while nempty (fall-through)
// half_full rises at DEPTH/2 entries; callers use it as their "full"
// push while full or pop while empty is illegal, nothing guards it here
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
   parameter int WIDTH = 8,
   parameter int DEPTH = 4
) (
   input  wire              aclk,
   input  wire              rst,
   input  wire              push,      // write din this cycle
   input  wire              pop,       // drop head this cycle
   input  wire  [WIDTH-1:0] din,
   output logic [WIDTH-1:0] dout,      // current head
   output logic             nempty,
   output logic             half_full
);

   localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_BITS = $clog2(DEPTH + 1);
   localparam logic [PTR_BITS-1:0] LAST_PTR = PTR_BITS'(DEPTH - 1);
   localparam logic [CNT_BITS-1:0] HALF_CNT = CNT_BITS'(DEPTH / 2);

   logic [WIDTH-1:0]    mem [DEPTH];   // storage, no reset
   logic [PTR_BITS-1:0] wr_ptr;
   logic [PTR_BITS-1:0] rd_ptr;
   logic [CNT_BITS-1:0] count;         // entries held

   // storage write
   always_ff @(posedge aclk) begin
      if (push) begin
         mem[wr_ptr] <= din;
      end
   end

   // pointers and occupancy
   always_ff @(posedge aclk or posedge rst) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1; // wrap for any depth
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;         // both or neither
         endcase
      end
   end

   assign dout      = mem[rd_ptr];
   assign nempty    = (count != '0);
   assign half_full = (count >= HALF_CNT);

   // callers must respect the flags; an overrun would silently lose an entry
   a_no_overflow: assert property (@(posedge aclk) disable iff (rst)
      push && !pop |-> count != CNT_BITS'(DEPTH))
      else $error("sync_fifo: push while full");

   a_no_underflow: assert property (@(posedge aclk) disable iff (rst)
      pop |-> count != '0)
      else $error("sync_fifo: pop while empty");

endmodule

`default_nettype wire

// File: logic/write_burst_ctrl.sv
// pairs one queued address with its data beats and writes them to memory
// a burst ends on whichever comes first of its beat count and wlast
// awsize is not seen here since every beat is one word
// WRAP assumes a legal awlen of 1, 3, 7 or 15 (window of 2..16 words)
`timescale 1ns/1ns
`default_nettype none

`include "axibram_defs.svh"

module write_burst_ctrl
   import axibram_pkg::*;
(
   input  wire                           aclk,
   input  wire                           rst,
   // address queue head
   input  wire                           aw_nempty,
   output logic                          aw_pop,    // burst start
   input  wire  [`AXIBRAM_ADDR_BITS-1:0] aw_addr,   // word address
   input  wire  [`AXIBRAM_LEN_BITS-1:0]  aw_len,
   input  wire  axi_burst_e              aw_burst,
   // data queue head
   input  wire                           w_nempty,
   output logic                          w_pop,     // one per memory write
   input  wire                           w_last,
   input  wire  [`AXIBRAM_ID_BITS-1:0]   w_id,
   // response queue
   input  wire                           b_full,
   output logic                          b_push,
   output logic [`AXIBRAM_ID_BITS-1:0]   b_id,
   // memory write port
   output logic                          mem_we,
   output logic [`AXIBRAM_ADDR_BITS-1:0] mem_addr
);

   logic                          in_prog;     // burst being written
   logic [`AXIBRAM_LEN_BITS-1:0]  left;        // beats after the current one
   axi_burst_e                    burst_r;
   logic [`AXIBRAM_LEN_BITS-1:0]  len_r;       // awlen that sets the wrap window
   logic [`AXIBRAM_ADDR_BITS-1:0] addr_r;      // current word address
   logic [`AXIBRAM_ADDR_BITS-1:0] addr_inc;
   logic [`AXIBRAM_ADDR_BITS-1:0] wrap_mask;   // low bits that move in WRAP
   logic [`AXIBRAM_ADDR_BITS-1:0] next_addr;
   logic                          beat_last;   // head beat closes the burst
   logic                          beat_ok;     // head beat written now
   logic                          start;

   assign beat_last = (left == '0) || w_last;
   // last beat waits for room in the response queue
   assign beat_ok   = in_prog && w_nempty && !(beat_last && b_full);
   assign start     = aw_nempty && w_nempty && (!in_prog || (beat_ok && beat_last));

   assign addr_inc  = addr_r + 1'b1;
   assign wrap_mask = {{(`AXIBRAM_ADDR_BITS - `AXIBRAM_LEN_BITS){1'b0}}, len_r};

   always_comb begin
      case (burst_r)
         BURST_INCR: next_addr = addr_inc;
         BURST_WRAP: next_addr = (addr_r & ~wrap_mask) | (addr_inc & wrap_mask); // keep upper bits
         default:    next_addr = addr_r;  // FIXED and RESERVED
      endcase
   end

   always_ff @(posedge aclk or posedge rst) begin
      if (rst) begin
         in_prog <= 1'b0;
         left    <= '0;
         burst_r <= BURST_FIXED;
         len_r   <= '0;
         addr_r  <= '0;
      end else begin
         if (start) begin
            in_prog <= 1'b1;               // may chain straight after a last beat
         end else if (beat_ok && beat_last) begin
            in_prog <= 1'b0;
         end

         if (start) begin
            left    <= aw_len;             // start wins over the decrement
            burst_r <= aw_burst;
            len_r   <= aw_len;
            addr_r  <= aw_addr;
         end else if (beat_ok) begin
            left    <= left - 1'b1;
            addr_r  <= next_addr;
         end
      end
   end

   assign aw_pop   = start;
   assign w_pop    = beat_ok;
   assign mem_we   = beat_ok;
   assign mem_addr = addr_r;
   assign b_push   = beat_ok && beat_last; // one response per burst
   assign b_id     = w_id;                 // id of the closing beat

   // the wrap window is aligned only for 2, 4, 8 or 16 beats
   a_wrap_window: assert property (@(posedge aclk) disable iff (rst)
      (start && aw_burst == BURST_WRAP) |-> (aw_len inside {4'd1, 4'd3, 4'd7, 4'd15}))
      else $error("write_burst_ctrl: wrap burst length has no aligned window");

endmodule

`default_nettype wire

// File: logic/byte_lane_bram.sv
// word memory with per-byte write enables
// read port is registered, rd_data follows rd_addr by one clock
// read and write of the same word in one cycle returns the old word
// contents are not cleared by reset
`timescale 1ns/1ns
`default_nettype none

`include "axibram_defs.svh"

module byte_lane_bram
   import axibram_pkg::*;
(
   input  wire                           aclk,
   input  wire                           we,
   input  wire  [`AXIBRAM_ADDR_BITS-1:0] waddr,
   input  wire  [`AXIBRAM_STRB_BITS-1:0] wstrb,  // byte lane enables
   input  wire  [`AXIBRAM_DATA_BITS-1:0] wdata,
   input  wire  [`AXIBRAM_ADDR_BITS-1:0] rd_addr,
   output logic [`AXIBRAM_DATA_BITS-1:0] rd_data
);

   localparam int WORDS = 1 << `AXIBRAM_ADDR_BITS;

   bram_word_u mem [WORDS];  // byte view for writes, word view for reads
   bram_word_u wr_word;
   bram_word_u rd_q;         // read register

   always_comb begin
      wr_word.word = wdata;
   end

   // strobed write, untouched lanes keep their bytes
   always_ff @(posedge aclk) begin
      if (we) begin
         for (int i = 0; i < `AXIBRAM_STRB_BITS; i++) begin
            if (wstrb[i]) begin
               mem[waddr].bytes[i] <= wr_word.bytes[i];
            end
         end
      end
   end

   // synchronous read
   always_ff @(posedge aclk) begin
      rd_q <= mem[rd_addr];
   end

   assign rd_data = rd_q.word;

endmodule

`default_nettype wire

// File: logic/axibram_write_top.sv
// write side of an AXI3 GP block-RAM slave with a single always-ready memory
// awsize must be 2 (4-byte beats) and lock, cache, prot and qos are not taken
// bursts are not interleaved and the wid of each burst must match its awid
// bresp is always OKAY
// awaddr above the memory size is ignored
// rd_addr / rd_data give a one-cycle read of the stored words
`timescale 1ns/1ns
`default_nettype none

`include "axibram_defs.svh"

module axibram_write_top
   import axibram_pkg::*;
(
   input  wire                           aclk,
   input  wire                           rst,
   // write address channel
   input  wire  [31:0]                   awaddr,
   input  wire                           awvalid,
   output logic                          awready,
   input  wire  [`AXIBRAM_ID_BITS-1:0]   awid,
   input  wire  [`AXIBRAM_LEN_BITS-1:0]  awlen,
   input  wire  [1:0]                    awsize,
   input  wire  [1:0]                    awburst,
   // write data channel
   input  wire  [`AXIBRAM_DATA_BITS-1:0] wdata,
   input  wire                           wvalid,
   output logic                          wready,
   input  wire  [`AXIBRAM_ID_BITS-1:0]   wid,
   input  wire                           wlast,
   input  wire  [`AXIBRAM_STRB_BITS-1:0] wstrb,
   // write response channel
   output logic                          bvalid,
   input  wire                           bready,
   output logic [`AXIBRAM_ID_BITS-1:0]   bid,
   output logic [1:0]                    bresp,
   // read-back port
   input  wire  [`AXIBRAM_ADDR_BITS-1:0] rd_addr,
   output logic [`AXIBRAM_DATA_BITS-1:0] rd_data
);

   localparam int AW_W = `AXIBRAM_ID_BITS + 2 + `AXIBRAM_LEN_BITS + `AXIBRAM_ADDR_BITS;
   localparam int W_W  = `AXIBRAM_ID_BITS + 1 + `AXIBRAM_STRB_BITS + `AXIBRAM_DATA_BITS;
   localparam int B_W  = `AXIBRAM_ID_BITS + 2;

   logic [AW_W-1:0]               aw_dout;
   logic                          aw_nempty, aw_half, aw_pop;
   logic [`AXIBRAM_ID_BITS-1:0]   aw_id_q;
   logic [1:0]                    aw_burst_q;
   logic [`AXIBRAM_LEN_BITS-1:0]  aw_len_q;
   logic [`AXIBRAM_ADDR_BITS-1:0] aw_addr_q;   // word address

   logic [W_W-1:0]                w_dout;
   logic                          w_nempty, w_half, w_pop;
   logic [`AXIBRAM_ID_BITS-1:0]   w_id_q;
   logic                          w_last_q;
   logic [`AXIBRAM_STRB_BITS-1:0] w_strb_q;
   logic [`AXIBRAM_DATA_BITS-1:0] w_data_q;

   logic [B_W-1:0]                b_dout;
   logic                          b_full, b_push;
   logic [`AXIBRAM_ID_BITS-1:0]   b_id;
   logic [1:0]                    resp_okay;

   logic                          mem_we;
   logic [`AXIBRAM_ADDR_BITS-1:0] mem_addr;

   assign awready   = ~aw_half;   // accept while below half
   assign wready    = ~w_half;
   assign resp_okay = RESP_OKAY;  // no error responses

   assign {aw_id_q, aw_burst_q, aw_len_q, aw_addr_q} = aw_dout;
   assign {w_id_q, w_last_q, w_strb_q, w_data_q}     = w_dout;
   assign {bid, bresp}                               = b_dout;

   sync_fifo #(.WIDTH(AW_W), .DEPTH(`AXIBRAM_FIFO_DEPTH)) aw_fifo_i (
      .aclk      (aclk),
      .rst       (rst),
      .push      (awvalid && awready),
      .pop       (aw_pop),
      .din       ({awid, awburst, awlen, awaddr[`AXIBRAM_ADDR_BITS+1:2]}), // byte -> word
      .dout      (aw_dout),
      .nempty    (aw_nempty),
      .half_full (aw_half)
   );

   sync_fifo #(.WIDTH(W_W), .DEPTH(`AXIBRAM_FIFO_DEPTH)) w_fifo_i (
      .aclk      (aclk),
      .rst       (rst),
      .push      (wvalid && wready),
      .pop       (w_pop),
      .din       ({wid, wlast, wstrb, wdata}),
      .dout      (w_dout),
      .nempty    (w_nempty),
      .half_full (w_half)
   );

   sync_fifo #(.WIDTH(B_W), .DEPTH(`AXIBRAM_FIFO_DEPTH)) b_fifo_i (
      .aclk      (aclk),
      .rst       (rst),
      .push      (b_push),
      .pop       (bvalid && bready),
      .din       ({b_id, resp_okay}),
      .dout      (b_dout),
      .nempty    (bvalid),     // response pending
      .half_full (b_full)      // stops last beats
   );

   write_burst_ctrl ctrl_i (
      .aclk      (aclk),
      .rst       (rst),
      .aw_nempty (aw_nempty),
      .aw_pop    (aw_pop),
      .aw_addr   (aw_addr_q),
      .aw_len    (aw_len_q),
      .aw_burst  (axi_burst_e'(aw_burst_q)),
      .w_nempty  (w_nempty),
      .w_pop     (w_pop),
      .w_last    (w_last_q),
      .w_id      (w_id_q),
      .b_full    (b_full),
      .b_push    (b_push),
      .b_id      (b_id),
      .mem_we    (mem_we),
      .mem_addr  (mem_addr)
   );

   byte_lane_bram bram_i (
      .aclk    (aclk),
      .we      (mem_we),
      .waddr   (mem_addr),
      .wstrb   (w_strb_q),
      .wdata   (w_data_q),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

   // only 4-byte beats are supported
   a_awsize_word: assert property (@(posedge aclk) disable iff (rst)
      awvalid && awready |-> awsize == 2'd2)
      else $error("axibram_write_top: awsize other than 4 bytes");

   // a start from idle finds the first beat of the new burst at the data head
   a_wid_matches: assert property (@(posedge aclk) disable iff (rst)
      aw_pop && !w_pop |-> w_id_q == aw_id_q)
      else $error("axibram_write_top: wid does not match awid at burst start");

endmodule

`default_nettype wire

// File: tb/tb_axibram_write.sv
// testbench for the AXI3 write-side BRAM slave
// memory is compared only on bytes that some burst has written
// each burst uses wid equal to its awid and bursts are issued in order
// inputs change 1 ns after a rising edge and ready and valid are sampled at the falling edge
`timescale 1ns/1ns
`default_nettype none

`include "axibram_defs.svh"

module tb_axibram_write
   import axibram_pkg::*;
();

   localparam int WORDS           = 1 << `AXIBRAM_ADDR_BITS;
   localparam int NUM_INCR        = 6;
   localparam int NUM_BP          = 6;
   localparam int TOTAL_BEATS     = 16 * (2 * NUM_INCR + NUM_BP) + 8 + 30;
   localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 40 + 12 * WORDS + 1000;
   localparam logic [31:0] BASE_ADDR = 32'h4000_0000;  // GP port window
   localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;  // x^32+x^22+x^2+x+1
   localparam logic [31:0] SEED      = 32'ha329_5e4b;

   logic                          aclk, rst;
   logic [31:0]                   awaddr;
   logic                          awvalid, awready;
   logic [`AXIBRAM_ID_BITS-1:0]   awid, wid, bid;
   logic [`AXIBRAM_LEN_BITS-1:0]  awlen;
   logic [1:0]                    awsize, awburst, bresp;
   logic [`AXIBRAM_DATA_BITS-1:0] wdata, rd_data;
   logic                          wvalid, wready, wlast, bvalid, bready;
   logic [`AXIBRAM_STRB_BITS-1:0] wstrb;
   logic [`AXIBRAM_ADDR_BITS-1:0] rd_addr;

   logic [31:0]                   lfsr_state;            // stimulus stream
   logic [31:0]                   bp_state;              // bready stream
   logic [31:0]                   ref_mem  [WORDS];      // model contents
   logic [31:0]                   ref_mask [WORDS];      // bytes ever written
   logic [`AXIBRAM_ID_BITS-1:0]   exp_ids  [$];          // awid order
   logic [31:0]                   beat_data [16];        // current burst
   logic [3:0]                    beat_strb [16];
   logic [1:0]                    beat_idle [16];        // wvalid gap before beat
   logic [`AXIBRAM_ADDR_BITS-1:0] starts [NUM_INCR];     // reused by partial test
   logic                          bready_hold;
   string                         cur_test;
   int                            errors, test_err_start, tests_passed, tests_failed;

   axibram_write_top uut (
      .aclk(aclk), .rst(rst),
      .awaddr(awaddr), .awvalid(awvalid), .awready(awready), .awid(awid),
      .awlen(awlen), .awsize(awsize), .awburst(awburst),
      .wdata(wdata), .wvalid(wvalid), .wready(wready), .wid(wid),
      .wlast(wlast), .wstrb(wstrb),
      .bvalid(bvalid), .bready(bready), .bid(bid), .bresp(bresp),
      .rd_addr(rd_addr), .rd_data(rd_data)
   );

   initial begin
      aclk = 1'b0;
      forever #5 aclk = ~aclk;
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);  // galois step to the right
   endfunction

   // one LFSR step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   // reference merge where strobed lanes take the new byte
   function automatic logic [31:0] merge_word(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  strb);
      logic [31:0] r;
      r = old_word;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) begin
            r[8*b +: 8] = new_word[8*b +: 8];
         end
      end
      return r;
   endfunction

   // reference word address of the following beat
   function automatic logic [`AXIBRAM_ADDR_BITS-1:0] next_word(
         input logic [`AXIBRAM_ADDR_BITS-1:0] a, input logic [3:0] len, input axi_burst_e burst);
      int size;
      int base;
      size = int'(len) + 1;
      base = int'(a) - (int'(a) % size);  // aligned wrap window
      case (burst)
         BURST_INCR: return a + 1'b1;
         BURST_WRAP: return `AXIBRAM_ADDR_BITS'(base + ((int'(a) - base + 1) % size));
         default:    return a;
      endcase
   endfunction

   task automatic compare_word(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         $display("FAIL %s: expected %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic send_addr(input logic [`AXIBRAM_ID_BITS-1:0] id,
                            input logic [`AXIBRAM_ADDR_BITS-1:0] word,
                            input logic [3:0] len, input axi_burst_e burst);
      logic taken;
      awid    = id;
      awaddr  = BASE_ADDR + 32'(word) * 32'd4;
      awlen   = len;
      awsize  = 2'd2;                       // 4-byte beats
      awburst = burst;
      awvalid = 1'b1;
      do begin
         @(negedge aclk);
         taken = awready;
         @(posedge aclk);
      end while (!taken);
      #1;
      awvalid = 1'b0;
   endtask

   task automatic send_data(input logic [`AXIBRAM_ID_BITS-1:0] id, input logic [3:0] len);
      logic taken;
      for (int i = 0; i <= int'(len); i++) begin
         if (beat_idle[i] != 2'd0) begin
            wvalid = 1'b0;
         end
         repeat (beat_idle[i]) begin
            @(posedge aclk);
            #1;
         end
         wid    = id;
         wdata  = beat_data[i];
         wstrb  = beat_strb[i];
         wlast  = (i == int'(len));
         wvalid = 1'b1;
         do begin
            @(negedge aclk);
            taken = wready;
            @(posedge aclk);
         end while (!taken);
         #1;
      end
      wvalid = 1'b0;
      wlast  = 1'b0;
   endtask

   // draws the burst and updates the model before driving both channels together
   task automatic do_burst(input axi_burst_e burst, input logic [`AXIBRAM_ADDR_BITS-1:0] word,
                           input logic [3:0] len, input logic part_strb, input logic gaps);
      logic [`AXIBRAM_ID_BITS-1:0]   id;
      logic [`AXIBRAM_ADDR_BITS-1:0] a;
      id = `AXIBRAM_ID_BITS'(rand_bits(`AXIBRAM_ID_BITS));
      a  = word;
      for (int i = 0; i <= int'(len); i++) begin
         beat_data[i] = rand_bits(32);
         beat_strb[i] = part_strb ? 4'(rand_bits(4)) : 4'hf;
         beat_idle[i] = gaps ? 2'(rand_bits(2)) : 2'd0;
         ref_mem[a]   = merge_word(ref_mem[a], beat_data[i], beat_strb[i]);
         ref_mask[a]  = merge_word(ref_mask[a], 32'hffff_ffff, beat_strb[i]);
         a = next_word(a, len, burst);
      end
      exp_ids.push_back(id);
      fork
         send_addr(id, word, len, burst);
         send_data(id, len);
      join
   endtask

   task automatic wait_responses();
      while (exp_ids.size() != 0) begin
         @(posedge aclk);
      end
      @(posedge aclk);
      #1;
   endtask

   // read back every word holding written bytes
   task automatic check_memory();
      logic [31:0] got;
      for (int w = 0; w < WORDS; w++) begin
         if (ref_mask[w] != '0) begin
            rd_addr = w[`AXIBRAM_ADDR_BITS-1:0];
            @(posedge aclk);                 // address sampled
            @(negedge aclk);
            got = rd_data;
            compare_word($sformatf("%s word %0d", cur_test, w),
                         ref_mem[w] & ref_mask[w], got & ref_mask[w]);
            @(posedge aclk);
            #1;
         end
      end
   endtask

   task automatic begin_test(input string name);
      cur_test       = name;
      test_err_start = errors;
   endtask

   task automatic end_test();
      if (errors == test_err_start) begin
         $display("test %s: passed", cur_test);
         tests_passed++;
      end else begin
         $display("test %s: failed with %0d mismatches", cur_test, errors - test_err_start);
         tests_failed++;
      end
   endtask

   // pops responses and checks that bid follows awid order
   initial begin : resp_monitor
      logic [`AXIBRAM_ID_BITS-1:0] exp;
      logic [1:0]                  ready_bits;
      bready   = 1'b0;
      bp_state = SEED;
      forever begin
         @(negedge aclk);
         if (bvalid && bready) begin
            if (exp_ids.size() == 0) begin
               $display("test %s: response arrived with no burst outstanding", cur_test);
               errors++;
            end else begin
               exp = exp_ids.pop_front();
               compare_word({cur_test, " bid"}, 32'(exp), 32'(bid));
               compare_word({cur_test, " bresp"}, 32'(RESP_OKAY), 32'(bresp));
            end
         end
         @(posedge aclk);
         #1;
         bp_state      = lfsr_next(bp_state);
         ready_bits[0] = bp_state[0];
         bp_state      = lfsr_next(bp_state);
         ready_bits[1] = bp_state[0];
         bready        = !bready_hold && (ready_bits != 2'b00);  // mostly ready
      end
   end

   initial begin : watchdog
      #(WATCHDOG_CYCLES * 10);
      $display("watchdog expired after %0d cycles during test %s", WATCHDOG_CYCLES, cur_test);
      $display("RESULT: FAIL");
      $finish;
   end

   initial begin : main
      logic [`AXIBRAM_ADDR_BITS-1:0] word;
      logic [3:0]                    len;
      logic [3:0]                    wrap_lens [4];
      wrap_lens   = '{4'd1, 4'd3, 4'd7, 4'd15};
      lfsr_state  = SEED;
      bready_hold = 1'b0;
      errors = 0;
      tests_passed = 0;
      tests_failed = 0;
      cur_test = "reset";
      rst = 1'b1;
      awaddr  = '0;
      awvalid = 1'b0;
      awid    = '0;
      awlen   = '0;
      awsize  = 2'd2;
      awburst = '0;
      wdata   = '0;
      wvalid  = 1'b0;
      wid     = '0;
      wlast   = 1'b0;
      wstrb   = '0;
      rd_addr = '0;
      for (int w = 0; w < WORDS; w++) begin
         ref_mem[w]  = '0;
         ref_mask[w] = '0;
      end
      repeat (10) @(posedge aclk);
      #1;
      rst = 1'b0;

      begin_test("reset");
      @(negedge aclk);
      compare_word("reset awready", 32'd1, 32'(awready));
      compare_word("reset wready", 32'd1, 32'(wready));
      compare_word("reset bvalid", 32'd0, 32'(bvalid));
      @(posedge aclk);
      #1;
      end_test();

      begin_test("incr_full");
      for (int n = 0; n < NUM_INCR; n++) begin
         starts[n] = `AXIBRAM_ADDR_BITS'(rand_bits(`AXIBRAM_ADDR_BITS));
         do_burst(BURST_INCR, starts[n], 4'(rand_bits(4)), 1'b0, 1'b0);
      end
      wait_responses();
      check_memory();
      end_test();

      begin_test("partial_strobe");                 // over the words just written
      for (int n = 0; n < NUM_INCR; n++) begin
         do_burst(BURST_INCR, starts[n], 4'(rand_bits(4)), 1'b1, 1'b0);
      end
      wait_responses();
      check_memory();
      end_test();

      begin_test("fixed_merge");
      word = `AXIBRAM_ADDR_BITS'(rand_bits(`AXIBRAM_ADDR_BITS));
      do_burst(BURST_FIXED, word, 4'd7, 1'b1, 1'b0);
      wait_responses();
      check_memory();
      end_test();

      begin_test("wrap");
      for (int n = 0; n < 4; n++) begin
         len  = wrap_lens[n];
         word = `AXIBRAM_ADDR_BITS'(rand_bits(`AXIBRAM_ADDR_BITS));
         if ((word & `AXIBRAM_ADDR_BITS'(len)) == '0) begin
            word = word | `AXIBRAM_ADDR_BITS'(1);     // start off the window base
         end
         do_burst(BURST_WRAP, word, len, 1'b0, 1'b0);
      end
      wait_responses();
      check_memory();
      end_test();

      begin_test("backpressure");
      bready_hold = 1'b1;
      fork
         begin
            for (int n = 0; n < NUM_BP; n++) begin
               word = `AXIBRAM_ADDR_BITS'(rand_bits(`AXIBRAM_ADDR_BITS));
               do_burst(BURST_INCR, word, 4'(rand_bits(4)), 1'b1, 1'b1);
            end
         end
         begin
            repeat (200) @(posedge aclk);         // let responses pile up
            bready_hold = 1'b0;
         end
      join
      wait_responses();
      check_memory();
      end_test();

      $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
      if (tests_failed == 0 && errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: files.f
+incdir+include
logic/axibram_pkg.sv
logic/sync_fifo.sv
logic/write_burst_ctrl.sv
logic/byte_lane_bram.sv
logic/axibram_write_top.sv
tb/tb_axibram_write.sv

// File: Makefile
# Verilator build and run of the AXI3 write-side BRAM testbench

VERILATOR ?= verilator
TOP       ?= tb_axibram_write
FILE_LIST ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(wildcard include/*.svh logic/*.sv tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@grep -q "RESULT: PASS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
